// File: common/axis_pkg.sv
// ----------------------------------------------------------
// AXI4-Stream receive side definitions: strobe width,
// TUSER layout and the encoded output beat
// ----------------------------------------------------------

package axis_pkg;

  // One strobe bit per data byte
  localparam int STRB_W = trn_pkg::DATA_W / 8;

  // ----------------------------------------------------------
  // TUSER, 22 bits, MSB first
  // ----------------------------------------------------------
  typedef struct packed {
    logic [4:0] is_eof;    // 21:17 enable + byte location
    logic [1:0] rsvd;      // 16:15 always zero
    logic [4:0] is_sof;    // 14:10 enable + byte location
    logic [7:0] bar_hit;   // 9:2
    logic       errfwd;    // 1
    logic       ecrc_err;  // 0
  } rx_tuser_t;

  // Encoded beat, stored in and emitted by the pipe
  typedef struct packed {
    logic [trn_pkg::DATA_W-1:0] data;
    logic [STRB_W-1:0]          strb;
    logic                       last;
    rx_tuser_t                  tuser;
  } axis_beat_t;  // 95 bits

  // Fixed location codes at 64 bits
  localparam logic [3:0] SOF_LOC_BYTE0 = 4'b0000;  // SOF only at byte 0
  localparam logic [1:0] EOF_LOC_LOW   = 2'b11;    // Low bits of EOF byte

endpackage

// File: common/trn_pkg.sv
// ----------------------------------------------------------
// TRN receive side definitions: widths, beat record,
// TLP header/address word views and MWr decode codes
// ----------------------------------------------------------

package trn_pkg;

  // Interface widths
  localparam int DATA_W    = 64;  // Fixed 64-bit datapath
  localparam int REM_W     = 1;   // One rem bit at 64 bits
  localparam int BAR_W_MAX = 8;   // Full BAR hit vector

  // One accepted TRN beat, BAR hit already widened
  typedef struct packed {
    logic [DATA_W-1:0]    data;
    logic                 sof;
    logic                 eof;
    logic [REM_W-1:0]     rem;
    logic                 errfwd;
    logic                 ecrc_err;
    logic [BAR_W_MAX-1:0] bar_hit;
  } trn_beat_t;

  // ----------------------------------------------------------
  // Two views of one data word. DW0 sits in the upper half.
  // ----------------------------------------------------------
  typedef struct packed {
    logic        rsvd;      // Bit 63
    logic [1:0]  fmt;       // Bits 62:61
    logic [4:0]  tlp_type;  // Bits 60:56
    logic [23:0] dw0_rest;  // TC, attr, length
    logic [31:0] dw1;       // Requester ID, tag, BEs
  } tlp_hdr_t;

  typedef struct packed {
    logic [31:0] upper;     // First dword on the wire
    logic [31:0] lower;
  } tlp_addr_t;

  typedef union packed {
    tlp_hdr_t  hdr;         // Start beat
    tlp_addr_t addr;        // Beat after the header start
  } tlp_word_u;

  // Memory write decode
  localparam logic [1:0] FMT_3DW_DATA = 2'b10;
  localparam logic [1:0] FMT_4DW_DATA = 2'b11;
  localparam logic [4:0] TYPE_MEM     = 5'b00000;  // MRd/MWr type

endpackage

// File: hdl/rx_beat_encode.sv
// ----------------------------------------------------------
// Receive beat encoder: raw TRN beat to AXI beat with
// strobes, SOF/EOF codes and widened BAR hit
// ----------------------------------------------------------
`timescale 1ns/10ps

module rx_beat_encode #(
  parameter int RBAR_W = 8  // 7 or 8
) (
  input  logic [trn_pkg::DATA_W-1:0] trn_rd,
  input  logic                       trn_rsof,
  input  logic                       trn_reof,
  input  logic [trn_pkg::REM_W-1:0]  trn_rrem,
  input  logic                       trn_rerrfwd,
  input  logic                       trn_recrc_err,
  input  logic [RBAR_W-1:0]          trn_rbar_hit,
  output axis_pkg::axis_beat_t       cur_beat
);

  trn_pkg::trn_beat_t             raw;      // Live TRN beat
  logic [trn_pkg::BAR_W_MAX-1:0]  bar_full; // Constant-width BAR hit

  // ----------------------------------------------------------
  // BAR hit widening
  // ----------------------------------------------------------
  if (RBAR_W == trn_pkg::BAR_W_MAX) begin : g_bar_full
    assign bar_full = trn_rbar_hit;
  end else begin : g_bar_narrow
    assign bar_full = {{(trn_pkg::BAR_W_MAX - RBAR_W){1'b0}}, trn_rbar_hit};
  end

  // Gather raw inputs
  assign raw.data     = trn_rd;
  assign raw.sof      = trn_rsof;
  assign raw.eof      = trn_reof;
  assign raw.rem      = trn_rrem;
  assign raw.errfwd   = trn_rerrfwd;
  assign raw.ecrc_err = trn_recrc_err;
  assign raw.bar_hit  = bar_full;

  // ----------------------------------------------------------
  // Encoding
  // ----------------------------------------------------------
  assign cur_beat.data = raw.data;  // No DW swap

  // Rem set means both dwords valid
  assign cur_beat.strb = raw.rem[0] ? 8'hFF : 8'h0F;
  assign cur_beat.last = raw.eof;

  // SOF always lands on byte 0 here
  assign cur_beat.tuser.is_sof = {raw.sof, axis_pkg::SOF_LOC_BYTE0};

  // EOF at byte 7 or byte 3
  assign cur_beat.tuser.is_eof   = {raw.eof, 1'b0, raw.rem, axis_pkg::EOF_LOC_LOW};
  assign cur_beat.tuser.rsvd     = 2'b00;
  assign cur_beat.tuser.bar_hit  = raw.bar_hit;
  assign cur_beat.tuser.errfwd   = raw.errfwd;
  assign cur_beat.tuser.ecrc_err = raw.ecrc_err;

endmodule

// File: hdl/rx_msi_detect.sv
// ----------------------------------------------------------
// Root-port MSI detector: flags memory writes whose address
// matches msi_address until the TLP leaves the AXI side
// ----------------------------------------------------------
`timescale 1ns/10ps

module rx_msi_detect #(
  parameter bit MSI_EN = 1'b1  // Root port only
) (
  input  logic                       com_iclk,
  input  logic                       com_sysrst,
  input  logic [trn_pkg::DATA_W-1:0] trn_rd,
  input  logic                       trn_rsof,
  input  logic                       trn_rsrc_rdy,
  input  logic                       trn_rdst_rdy,
  input  logic [63:0]                msi_address,
  input  logic                       m_axis_rx_tvalid,
  input  logic                       m_axis_rx_tready,
  input  logic                       m_axis_rx_tlast,
  output logic                       is_msi_trn
);

  if (MSI_EN) begin : g_msi
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_ADDR_3DW = 2'd1;  // Address in upper dword
    localparam logic [1:0] ST_ADDR_4DW = 2'd2;  // Full 64-bit address

    trn_pkg::tlp_word_u rd_word;
    logic [1:0]         state;
    logic               beat_acc;
    logic               addr_hit;
    logic               axi_eop;

    assign rd_word  = trn_rd;
    assign beat_acc = trn_rsrc_rdy && trn_rdst_rdy;
    assign axi_eop  = m_axis_rx_tvalid && m_axis_rx_tready && m_axis_rx_tlast;

    // ----------------------------------------------------------
    // Header decode
    // ----------------------------------------------------------
    always_ff @(posedge com_iclk) begin
      if (com_sysrst) begin
        state <= ST_IDLE;
      end else if (beat_acc) begin
        if (state == ST_IDLE) begin
          if (trn_rsof && rd_word.hdr.tlp_type == trn_pkg::TYPE_MEM) begin
            if (rd_word.hdr.fmt == trn_pkg::FMT_3DW_DATA) begin
              state <= ST_ADDR_3DW;
            end else if (rd_word.hdr.fmt == trn_pkg::FMT_4DW_DATA) begin
              state <= ST_ADDR_4DW;
            end
          end
        end else begin
          state <= ST_IDLE;  // Address beat consumed
        end
      end
    end

    // Compare only on an accepted address beat
    always_comb begin
      case (state)
        ST_ADDR_3DW: addr_hit = beat_acc && (msi_address == {32'h0, rd_word.addr.upper});
        ST_ADDR_4DW: addr_hit = beat_acc && (msi_address == rd_word);
        default:     addr_hit = 1'b0;
      endcase
    end

    // Sticky flag, set wins over clear
    always_ff @(posedge com_iclk) begin
      if (com_sysrst) begin
        is_msi_trn <= 1'b0;
      end else if (addr_hit) begin
        is_msi_trn <= 1'b1;
      end else if (axi_eop) begin
        is_msi_trn <= 1'b0;
      end
    end
  end else begin : g_no_msi
    assign is_msi_trn = 1'b0;  // Endpoint
  end

endmodule

// File: hdl/trn_axi_rx.sv
// ----------------------------------------------------------
// TRN to AXI4-Stream receive bridge, 64-bit datapath
// ----------------------------------------------------------
`timescale 1ns/10ps

module trn_axi_rx #(
  parameter int RBAR_W = 8,    // 7 or 8 BAR hit bits
  parameter bit MSI_EN = 1'b1  // 1 for root port
) (
  input  logic                                   com_iclk,
  input  logic                                   com_sysrst,
  // TRN receive
  input  logic [trn_pkg::DATA_W-1:0]             trn_rd,
  input  logic                                   trn_rsof,
  input  logic                                   trn_reof,
  input  logic [trn_pkg::REM_W-1:0]              trn_rrem,
  input  logic                                   trn_rsrc_rdy,
  output logic                                   trn_rdst_rdy,
  input  logic                                   trn_rerrfwd,
  input  logic                                   trn_recrc_err,
  input  logic [RBAR_W-1:0]                      trn_rbar_hit,
  // AXI4-Stream master
  output logic [trn_pkg::DATA_W-1:0]             m_axis_rx_tdata,
  output logic [axis_pkg::STRB_W-1:0]            m_axis_rx_tstrb,
  output logic                                   m_axis_rx_tlast,
  output logic [$bits(axis_pkg::rx_tuser_t)-1:0] m_axis_rx_tuser,
  output logic                                   m_axis_rx_tvalid,
  input  logic                                   m_axis_rx_tready,
  // MSI
  input  logic [63:0]                            msi_address,
  output logic                                   is_msi_trn
);

  axis_pkg::axis_beat_t cur_beat;  // Encoded live beat
  axis_pkg::axis_beat_t out_beat;  // Registered output word

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  rx_beat_encode #(.RBAR_W(RBAR_W)) u_encode (
    .trn_rd        (trn_rd),
    .trn_rsof      (trn_rsof),
    .trn_reof      (trn_reof),
    .trn_rrem      (trn_rrem),
    .trn_rerrfwd   (trn_rerrfwd),
    .trn_recrc_err (trn_recrc_err),
    .trn_rbar_hit  (trn_rbar_hit),
    .cur_beat      (cur_beat)
  );

  rx_axis_pipe u_pipe (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .cur_beat         (cur_beat),
    .trn_rsrc_rdy     (trn_rsrc_rdy),
    .m_axis_rx_tready (m_axis_rx_tready),
    .out_beat         (out_beat),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .trn_rdst_rdy     (trn_rdst_rdy)
  );

  rx_msi_detect #(.MSI_EN(MSI_EN)) u_msi (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .trn_rd           (trn_rd),
    .trn_rsof         (trn_rsof),
    .trn_rsrc_rdy     (trn_rsrc_rdy),
    .trn_rdst_rdy     (trn_rdst_rdy),
    .msi_address      (msi_address),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tready (m_axis_rx_tready),
    .m_axis_rx_tlast  (m_axis_rx_tlast),
    .is_msi_trn       (is_msi_trn)
  );

  // Unpack output word onto the bus
  assign m_axis_rx_tdata = out_beat.data;
  assign m_axis_rx_tstrb = out_beat.strb;
  assign m_axis_rx_tlast = out_beat.last;
  assign m_axis_rx_tuser = out_beat.tuser;

endmodule

// File: project.f
common/trn_pkg.sv
common/axis_pkg.sv
hdl/rx_beat_encode.sv
rx_pipe/rx_axis_pipe.sv
hdl/rx_msi_detect.sv
hdl/trn_axi_rx.sv
verif/tb_clkgen.sv
verif/trn_axi_rx_props.sv
verif/tb_trn_axi_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the TRN to AXI receive bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_trn_axi_rx
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module "$TOP" -f project.f

./obj_dir/V"$TOP" | tee "$LOG"

# Verdict comes from the log
if grep -qx "Simulation passed" "$LOG"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: rx_pipe/rx_axis_pipe.sv
// ----------------------------------------------------------
// Receive pipeline stage between TRN and AXI with a
// previous-value buffer so user throttling drops nothing
// ----------------------------------------------------------
`timescale 1ns/10ps

module rx_axis_pipe (
  input  logic                 com_iclk,
  input  logic                 com_sysrst,
  input  axis_pkg::axis_beat_t cur_beat,          // From encoder, comb
  input  logic                 trn_rsrc_rdy,
  input  logic                 m_axis_rx_tready,
  output axis_pkg::axis_beat_t out_beat,
  output logic                 m_axis_rx_tvalid,
  output logic                 trn_rdst_rdy
);

  axis_pkg::axis_beat_t prev_beat;  // Last beat seen while ready
  logic                 prev_vld;   // It was a real transfer
  logic                 cur_vld;    // Beat accepted this cycle
  logic                 data_hold;  // Output stalled by user
  logic                 data_prev;  // Drain buffer next

  assign cur_vld   = trn_rsrc_rdy && trn_rdst_rdy;
  assign data_hold = m_axis_rx_tvalid && !m_axis_rx_tready;

  // ----------------------------------------------------------
  // Previous-value buffer
  // ----------------------------------------------------------
  // The registered ready lags the user by one cycle, so one
  // more beat can slip in after tready drops. It parks here.
  always_ff @(posedge com_iclk) begin
    if (trn_rdst_rdy) begin
      prev_beat <= cur_beat;  // Payload only
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      prev_vld  <= 1'b0;
      data_prev <= 1'b0;
    end else begin
      if (trn_rdst_rdy) begin
        prev_vld <= cur_vld;
      end
      data_prev <= data_hold;  // Always drain after a hold
    end
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------
  // Hold: keep word while valid and not taken
  // Previous: emit the parked beat
  // Current: emit the live beat
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      out_beat         <= '0;  // tlast low out of reset
      m_axis_rx_tvalid <= 1'b0;
    end else if (!data_hold) begin
      if (data_prev) begin
        out_beat         <= prev_beat;
        m_axis_rx_tvalid <= prev_vld;
      end else begin
        out_beat         <= cur_beat;
        m_axis_rx_tvalid <= cur_vld;  // Ready is low the cycle after reset
      end
    end
  end

  // ----------------------------------------------------------
  // Destination ready
  // ----------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      trn_rdst_rdy <= 1'b0;
    end else if (m_axis_rx_tvalid) begin
      trn_rdst_rdy <= m_axis_rx_tready;  // Pass user back-pressure
    end else begin
      // Idle, stay open so the next SOF is not missed
      trn_rdst_rdy <= 1'b1;
    end
  end

endmodule

// File: verif/tb_clkgen.sv
// ----------------------------------------------------------
// Testbench clock and reset source, 8 ns period
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
) (
  output logic com_iclk,
  output logic com_sysrst
);

  initial begin
    com_iclk = 1'b0;
    forever #(PERIOD_NS / 2) com_iclk = ~com_iclk;
  end

  // Release just after an edge, like any other input
  initial begin
    com_sysrst = 1'b1;
    repeat (RST_CYCLES) @(posedge com_iclk);
    #1 com_sysrst = 1'b0;
  end

endmodule

// File: verif/tb_trn_axi_rx.sv
// ----------------------------------------------------------
// Testbench for the TRN to AXI4-Stream receive bridge with
// random TLPs and throttling against a beat queue model
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_trn_axi_rx;

  localparam int N_TLP     = 50;                    // Per traffic test
  localparam int MAX_BEATS = 2 * N_TLP * 6;         // Two tests of up to 6 beats per TLP
  localparam int CYC_LIMIT = 10 * MAX_BEATS + 200;
  localparam logic [31:0] SEED = 32'h19be5f11;

  logic        com_iclk, com_sysrst;
  logic [63:0] trn_rd, m_axis_rx_tdata, msi_address;
  logic        trn_rsof, trn_reof, trn_rsrc_rdy, trn_rdst_rdy;
  logic [0:0]  trn_rrem;
  logic        trn_rerrfwd, trn_recrc_err;
  logic [7:0]  trn_rbar_hit, m_axis_rx_tstrb;
  logic        m_axis_rx_tlast, m_axis_rx_tvalid, m_axis_rx_tready, is_msi_trn;
  logic [21:0] m_axis_rx_tuser;

  logic [94:0] exp_q[$];   // {data, strb, last, tuser} per accepted beat
  int          acc_q[$];   // Acceptance cycle per beat
  int          len_q[$];   // Beats per TLP
  bit          msi_q[$];   // Expected MSI match per TLP
  int          cyc = 0, err_cnt = 0, fail_tests = 0;
  int          beat_idx = 0, tlp_acc = 0, addr_tlp = -1, tlp_done = 0;
  bit          clr_chk = 0, lat_chk = 0, ready_rand = 0;

  tb_clkgen u_clk (.com_iclk(com_iclk), .com_sysrst(com_sysrst));

  trn_axi_rx #(.RBAR_W(8), .MSI_EN(1'b1)) dut (.*);

  always @(posedge com_iclk) cyc <= cyc + 1;

  task automatic value_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // ----------------------------------------------------------
  // Monitor at mid-cycle when everything has settled
  // ----------------------------------------------------------
  always @(negedge com_iclk) begin : mon
    logic [94:0] got, exp_w;
    int          acc, len;
    bit          hit;
    if (!com_sysrst) begin
      if (m_axis_rx_tvalid && m_axis_rx_tready) begin
        got = {m_axis_rx_tdata, m_axis_rx_tstrb, m_axis_rx_tlast, m_axis_rx_tuser};
        if (exp_q.size() == 0) begin
          $display("Unexpected AXI transfer at %0t with no accepted beat pending", $time);
          err_cnt++;
        end else begin
          exp_w = exp_q.pop_front();
          acc   = acc_q.pop_front();
          if (got[94:31] !== exp_w[94:31])
            value_error($sformatf("tdata %h, expected %h", got[94:31], exp_w[94:31]));
          if (got[30:23] !== exp_w[30:23])
            value_error($sformatf("tstrb %h, expected %h", got[30:23], exp_w[30:23]));
          if (got[22] !== exp_w[22])
            value_error($sformatf("tlast %b, expected %b", got[22], exp_w[22]));
          if (got[21:0] !== exp_w[21:0])
            value_error($sformatf("tuser %h, expected %h", got[21:0], exp_w[21:0]));
          if (lat_chk && cyc != acc + 1)
            value_error($sformatf("beat latency %0d cycles, expected 1", cyc - acc));
        end
        // Flag must be gone unless the next address beat is already in
        if (clr_chk) begin
          if (is_msi_trn !== 1'b0 && addr_tlp < tlp_done)
            value_error("is_msi_trn still set after end of TLP");
          clr_chk = 1'b0;
        end
        if (m_axis_rx_tlast && len_q.size() != 0) begin
          len = len_q.pop_front();
          hit = msi_q.pop_front();
          if (len >= 2 && is_msi_trn !== hit)
            value_error($sformatf("is_msi_trn %b at TLP %0d end, expected %b",
                                  is_msi_trn, tlp_done, hit));
          tlp_done++;
          clr_chk = 1'b1;
        end
      end
      // Model takes the beat and encodes it
      if (trn_rsrc_rdy && trn_rdst_rdy) begin
        exp_q.push_back({trn_rd, (trn_rrem[0] ? 8'hFF : 8'h0F), trn_reof,
                         trn_reof, 1'b0, trn_rrem, 2'b11, 2'b00, trn_rsof, 4'b0000,
                         trn_rbar_hit, trn_rerrfwd, trn_recrc_err});
        acc_q.push_back(cyc);
        beat_idx = trn_rsof ? 0 : beat_idx + 1;
        if (trn_rsof) tlp_acc++;
        if (beat_idx == 1) addr_tlp = tlp_acc - 1;  // Address beat of this TLP
      end
    end
  end

  // ----------------------------------------------------------
  // Driver
  // ----------------------------------------------------------
  task automatic cycle_step();
    @(posedge com_iclk);
    #1;
    m_axis_rx_tready = ready_rand ? ($urandom_range(0, 3) != 0) : 1'b1;
  endtask

  task automatic put_beat(input logic [63:0] d, input logic sof, input logic eof,
                          input logic rem);
    bit taken;
    taken        = 1'b0;
    trn_rd       = d;
    trn_rsof     = sof;
    trn_reof     = eof;
    trn_rrem     = rem;
    while (!taken) begin
      trn_rsrc_rdy = ($urandom_range(0, 3) != 0);
      @(negedge com_iclk);
      taken = trn_rsrc_rdy && trn_rdst_rdy;
      cycle_step();
    end
  endtask

  task automatic send_tlp();
    trn_pkg::tlp_word_u hw;
    logic [63:0]        addr_w, d;
    int                 len, b;
    bit                 is4, hit;
    len = $urandom_range(1, 6);
    is4 = ($urandom_range(0, 1) == 1);
    hit = ($urandom_range(0, 1) == 1);
    trn_rbar_hit  = 8'($urandom);
    trn_rerrfwd   = ($urandom_range(0, 7) == 0);
    trn_recrc_err = ($urandom_range(0, 7) == 0);
    // Single-beat TLPs get a read header since writes need an address beat
    hw.hdr.rsvd     = 1'b0;
    hw.hdr.fmt      = (len == 1) ? 2'b00 :
                      (is4 ? trn_pkg::FMT_4DW_DATA : trn_pkg::FMT_3DW_DATA);
    hw.hdr.tlp_type = trn_pkg::TYPE_MEM;
    hw.hdr.dw0_rest = 24'($urandom);
    hw.hdr.dw1      = $urandom;
    if (is4) addr_w = hit ? msi_address : {$urandom, $urandom};
    else     addr_w = {(hit ? msi_address[31:0] : $urandom), $urandom};
    len_q.push_back(len);
    msi_q.push_back((len >= 2) && (is4 ? (msi_address == addr_w)
                                       : (msi_address == {32'h0, addr_w[63:32]})));
    for (b = 0; b < len; b++) begin
      d = (b == 0) ? hw : ((b == 1) ? addr_w : {$urandom, $urandom});
      put_beat(d, (b == 0), (b == len - 1),
               (b == len - 1) ? ($urandom_range(0, 1) == 1) : 1'b1);
    end
  endtask

  task automatic close_test(input string name, input int errs);
    $display("Test %s: %s, %0d errors", name, (err_cnt == errs) ? "ok" : "FAILED",
             err_cnt - errs);
    if (err_cnt != errs) fail_tests++;
  endtask

  task automatic run_stream(input string name, input bit rand_rdy, input logic [63:0] addr);
    int errs, i;
    errs = err_cnt;
    cycle_step();
    msi_address = addr;
    ready_rand  = rand_rdy;
    lat_chk     = !rand_rdy;  // Fixed latency only without throttling
    for (i = 0; i < N_TLP; i++) send_tlp();
    trn_rsrc_rdy = 1'b0;
    while (exp_q.size() != 0) cycle_step();
    cycle_step();
    close_test(name, errs);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : main
    int errs;
    void'($urandom(SEED));
    trn_rd = '0;
    trn_rsof = 1'b0;
    trn_reof = 1'b0;
    trn_rrem = 1'b0;
    trn_rsrc_rdy = 1'b0;
    trn_rerrfwd = 1'b0;
    trn_recrc_err = 1'b0;
    trn_rbar_hit = '0;
    m_axis_rx_tready = 1'b1;
    msi_address = '0;
    errs = err_cnt;
    @(posedge com_iclk);  // Outputs settle at the first reset edge
    @(negedge com_iclk);
    while (com_sysrst) begin
      if (m_axis_rx_tvalid !== 1'b0 || m_axis_rx_tlast !== 1'b0 ||
          trn_rdst_rdy !== 1'b0 || is_msi_trn !== 1'b0)
        value_error("outputs not low during reset");
      @(negedge com_iclk);
    end
    if (trn_rdst_rdy !== 1'b0) value_error("trn_rdst_rdy high in first cycle after reset");
    @(negedge com_iclk);
    if (trn_rdst_rdy !== 1'b1) value_error("trn_rdst_rdy low one cycle after reset");
    close_test("reset", errs);
    run_stream("ready_high", 1'b0, {32'h0, $urandom & 32'hFFFF_FFFC});
    run_stream("ready_random", 1'b1, {$urandom | 32'h1, $urandom & 32'hFFFF_FFFC});
    err_cnt += int'(dut.u_pipe.u_props.fail_cnt);
    $display("Tests run: 3, failed: %0d, errors: %0d, assertion failures: %0d",
             fail_tests, err_cnt, dut.u_pipe.u_props.fail_cnt);
    if (err_cnt == 0 && fail_tests == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cyc >= CYC_LIMIT);
    $display("Timeout: run passed %0d cycles, beats stalled or lost", CYC_LIMIT);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verif/trn_axi_rx_props.sv
// ----------------------------------------------------------
// Pipe properties: held word stability, ready response
// to back-pressure and quiet output during reset
// ----------------------------------------------------------
`timescale 1ns/10ps

module trn_axi_rx_props (
  input logic                 com_iclk,
  input logic                 com_sysrst,
  input axis_pkg::axis_beat_t out_beat,
  input logic                 m_axis_rx_tvalid,
  input logic                 m_axis_rx_tready,
  input logic                 trn_rdst_rdy
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end
  logic        held;          // Output stalled this cycle

  assign held = m_axis_rx_tvalid && !m_axis_rx_tready;

  // Word and valid stay put until taken
  a_hold_stable: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    held |=> $stable(out_beat) && m_axis_rx_tvalid)
    else begin
      fail_cnt++;
      $error("held AXI word changed before transfer");
    end

  // Registered ready follows the stall
  a_rdy_drop: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    held |=> !trn_rdst_rdy)
    else begin
      fail_cnt++;
      $error("trn_rdst_rdy high after a held output");
    end

  a_rst_quiet: assert property (@(posedge com_iclk)
    com_sysrst |=> !m_axis_rx_tvalid)
    else begin
      fail_cnt++;
      $error("tvalid high during reset");
    end

endmodule

bind rx_axis_pipe trn_axi_rx_props u_props (
  .com_iclk         (com_iclk),
  .com_sysrst       (com_sysrst),
  .out_beat         (out_beat),
  .m_axis_rx_tvalid (m_axis_rx_tvalid),
  .m_axis_rx_tready (m_axis_rx_tready),
  .trn_rdst_rdy     (trn_rdst_rdy)
);
